// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Simulation passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)

sim: build
	-./$(BUILD_DIR)/$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) && echo "result: pass" || \
	  (echo "result: fail"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/branch_predictor.sv ====
`timescale 1ns/10ps

module branch_predictor (
  input  logic               clk,
  input  logic               rst,
  input  fetch_pkg::bp_in_t  bp_in,
  output fetch_pkg::bp_out_t bp_out
);
  import fetch_pkg::*;

  logic                    btb_valid [btb_entries];
  logic [1:0]              btb_cnt [btb_entries];
  logic [btb_tag_bits-1:0] btb_tag [btb_entries];
  logic [xlen-1:0]         btb_target [btb_entries];
  logic [xlen-1:0]         ras [ras_depth];

  logic [btb_bits-1:0]     get_idx;
  logic [btb_bits-1:0]     upd_idx;
  logic [btb_tag_bits-1:0] upd_tag;
  logic                    get_hit;
  logic                    upd_hit;
  logic                    upd_en;
  logic [1:0]              cnt_base;
  logic [1:0]              cnt_next;
  logic [ras_bits-1:0]     ras_ptr;  // next free slot.
  logic [ras_bits-1:0]     ras_top;
  logic [ras_bits:0]       ras_cnt;
  logic                    ras_push;
  logic                    ras_pop;

  always_comb begin
    get_idx = bp_in.get_pc[btb_bits:1];
    get_hit = btb_valid[get_idx] && btb_tag[get_idx] == bp_in.get_pc[xlen-1:btb_bits+1];
    ras_top = ras_ptr - 1'b1;

    bp_out.pred_branch = bp_in.get_branch & get_hit;
    bp_out.pred_jump = get_hit & btb_cnt[get_idx][1];
    bp_out.pred_uncond = bp_in.get_uncond & get_hit;
    bp_out.pred_return = bp_in.get_return & (ras_cnt != '0);
    bp_out.pred_baddr = btb_target[get_idx];
    bp_out.pred_raddr = ras[ras_top];

    upd_idx = bp_in.upd_pc[btb_bits:1];
    upd_tag = bp_in.upd_pc[xlen-1:btb_bits+1];
    upd_hit = btb_valid[upd_idx] && btb_tag[upd_idx] == upd_tag;
    upd_en = (bp_in.upd_branch | bp_in.upd_uncond) & ~bp_in.stall;

    // a new entry starts from weakly not-taken before this outcome is counted.
    cnt_base = upd_hit ? btb_cnt[upd_idx] : ctr_weak_nt;
    if (bp_in.upd_jump) begin
      cnt_next = (cnt_base == 2'b11) ? cnt_base : cnt_base + 2'b01;
    end else begin
      cnt_next = (cnt_base == 2'b00) ? cnt_base : cnt_base - 2'b01;
    end

    ras_push = bp_in.upd_return & ~bp_in.stall;
    ras_pop = bp_out.pred_return & ~bp_in.stall;
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      for (int i = 0; i < btb_entries; i++) begin
        btb_valid[i] <= 1'b0;
        btb_cnt[i] <= ctr_weak_nt;
      end
    end else if (upd_en) begin
      btb_valid[upd_idx] <= 1'b1;
      btb_cnt[upd_idx] <= cnt_next;
    end
  end

  always_ff @(posedge clk) begin
    if (upd_en) begin
      btb_tag[upd_idx] <= upd_tag;
      if (bp_in.upd_jump) begin
        btb_target[upd_idx] <= bp_in.upd_addr;  // a not-taken branch keeps its target.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst || bp_in.clear) begin
      ras_ptr <= '0;
      ras_cnt <= '0;
    end else if (ras_push && !ras_pop) begin
      ras_ptr <= ras_ptr + 1'b1;  // the oldest entry is overwritten when full.
      if (ras_cnt != ras_depth) begin
        ras_cnt <= ras_cnt + 1'b1;
      end
    end else if (ras_pop && !ras_push) begin
      ras_ptr <= ras_top;
      ras_cnt <= ras_cnt - 1'b1;
    end
  end

  // a push and a pop together replace the top entry.
  always_ff @(posedge clk) begin
    if (ras_push) begin
      ras[ras_pop ? ras_top : ras_ptr] <= bp_in.upd_npc;
    end
  end

endmodule

// ==== design/fetch_buffer.sv ====
`timescale 1ns/10ps

module fetch_buffer (
  input  logic                clk,
  input  logic                rst,
  input  fetch_pkg::mem_req_t mem_req,
  output fetch_pkg::mem_rsp_t mem_rsp
);
  import fetch_pkg::*;

  logic [15:0]          mem [imem_depth];
  logic [imem_bits-1:0] lo_idx;
  logic [imem_bits-1:0] hi_idx;
  logic                 in_range;
  logic                 flush;  // buffer flush after a fence.

  initial begin
    for (int i = 0; i < imem_depth; i++) begin
      mem[i] = fill_half;
    end
    $readmemh("design/program.hex", mem);  // one halfword per entry.
  end

  // any halfword may start an instruction, so two halfwords are read.
  always_comb begin
    lo_idx = mem_req.addr[imem_bits:1];
    hi_idx = lo_idx + 1'b1;  // wraps at the top of memory.
    in_range = (mem_req.addr[xlen-1:imem_bits+1] == '0);

    mem_rsp.ready = mem_req.valid & ~flush;
    if (in_range) begin
      mem_rsp.rdata = {mem[hi_idx], mem[lo_idx]};
    end else begin
      mem_rsp.rdata = nop_instr;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      flush <= 1'b0;
    end else begin
      flush <= mem_req.valid & mem_req.fence;  // one not-ready cycle per fence.
    end
  end

endmodule

// ==== design/fetch_pkg.sv ====
package fetch_pkg;

  localparam int xlen = 32;
  localparam int imem_depth = 256;
  localparam int imem_bits = $clog2(imem_depth);
  localparam int btb_entries = 16;
  localparam int btb_bits = $clog2(btb_entries);
  localparam int btb_tag_bits = xlen - btb_bits - 1;
  localparam int ras_depth = 4;
  localparam int ras_bits = $clog2(ras_depth);

  localparam logic [xlen-1:0] reset_pc = '0;
  localparam logic [xlen-1:0] nop_instr = 32'h0000_0013;  // addi x0, x0, 0.
  localparam logic [15:0] fill_half = 16'h0001;  // c.nop fills memory past the image.
  localparam logic [1:0] ctr_weak_nt = 2'b01;

  // reason the fetch pc changed, in priority order.
  typedef enum logic [2:0] {
    redir_trap,
    redir_mret,
    redir_repair,
    redir_pred_return,
    redir_pred_jump,
    redir_fence,
    redir_seq,
    redir_hold
  } redirect_e;

  typedef enum logic {
    csr_mtvec,
    csr_mepc
  } csr_sel_e;

  typedef struct packed {
    logic            trap;
    logic            mret;
    logic [xlen-1:0] mtvec;
    logic [xlen-1:0] mepc;
  } csr_out_t;

  typedef struct packed {
    logic [xlen-1:0] get_pc;
    logic            get_branch;
    logic            get_return;
    logic            get_uncond;
    logic [xlen-1:0] upd_pc;
    logic [xlen-1:0] upd_npc;
    logic [xlen-1:0] upd_addr;
    logic            upd_branch;
    logic            upd_return;
    logic            upd_uncond;
    logic            upd_jump;
    logic            stall;
    logic            clear;
  } bp_in_t;

  typedef struct packed {
    logic            pred_branch;
    logic            pred_jump;
    logic            pred_return;
    logic            pred_uncond;
    logic [xlen-1:0] pred_baddr;
    logic [xlen-1:0] pred_raddr;
  } bp_out_t;

  typedef struct packed {
    logic            valid;
    logic            fence;
    logic [xlen-1:0] addr;
  } mem_req_t;

  typedef struct packed {
    logic            ready;
    logic [xlen-1:0] rdata;
  } mem_rsp_t;

  // feedback from decode (d_), execute (e_), memory (m_) and writeback (w_).
  typedef struct packed {
    logic [xlen-1:0] d_pc;
    logic [xlen-1:0] d_npc;
    logic            d_branch;
    logic            d_return_pop;
    logic            d_jump_uncond;
    logic [xlen-1:0] e_pc;
    logic [xlen-1:0] e_npc;
    logic [xlen-1:0] e_address;
    logic            e_branch;
    logic            e_return_push;
    logic            e_jump_uncond;
    logic            e_jump;
    logic            m_fence;
    logic            w_clear;
    logic            d_stall;
    logic            e_stall;
    logic            m_stall;
    logic [xlen-1:0] f_pc;  // pc fetched after the instruction now in execute.
    logic            f_taken;
  } backend_t;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] instr;
    logic            taken;
    redirect_e       src;
  } fetch_out_t;

endpackage

// ==== design/fetch_stage.sv ====
`timescale 1ns/10ps

module fetch_stage (
  input  logic                  clk,
  input  logic                  rst,
  input  fetch_pkg::csr_out_t   csr_out,
  input  fetch_pkg::bp_out_t    bp_out,
  output fetch_pkg::bp_in_t     bp_in,
  input  fetch_pkg::mem_rsp_t   mem_rsp,
  output fetch_pkg::mem_req_t   mem_req,
  input  fetch_pkg::backend_t   backend,
  output fetch_pkg::fetch_out_t y,
  output fetch_pkg::fetch_out_t q
);
  import fetch_pkg::*;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] instr;
    logic            taken;
    logic            stall;
    redirect_e       src;
  } fetch_reg_t;

  fetch_reg_t r;
  fetch_reg_t sel;
  fetch_reg_t rin;
  logic       backpressure;
  logic       busy;
  logic       valid;

  always_comb begin
    backpressure = backend.d_stall | backend.e_stall | backend.m_stall | backend.w_clear;
    busy = r.stall | backpressure;  // last fetch missed or the pipe is held.

    bp_in.get_pc = backend.d_pc;
    bp_in.get_branch = backend.d_branch;
    bp_in.get_return = backend.d_return_pop;
    bp_in.get_uncond = backend.d_jump_uncond;
    bp_in.upd_pc = backend.e_pc;
    bp_in.upd_npc = backend.e_npc;
    bp_in.upd_addr = backend.e_address;
    bp_in.upd_branch = backend.e_branch;
    bp_in.upd_return = backend.e_return_push;
    bp_in.upd_uncond = backend.e_jump_uncond;
    bp_in.upd_jump = backend.e_jump;
    bp_in.stall = busy;
    bp_in.clear = backend.w_clear;
  end

  always_comb begin
    sel = r;
    sel.taken = 1'b0;
    mem_req.fence = 1'b0;
    valid = ~backpressure | backend.m_fence;

    if (csr_out.trap) begin
      sel.pc = csr_out.mtvec;
      sel.src = redir_trap;
      valid = 1'b1;
    end else if (csr_out.mret) begin
      sel.pc = csr_out.mepc;
      sel.src = redir_mret;
      valid = 1'b1;
    end else if (backend.e_jump && (!backend.f_taken || backend.e_address != backend.f_pc)) begin
      sel.pc = backend.e_address;  // missed jump or wrong target.
      sel.src = redir_repair;
      valid = 1'b1;
    end else if (!backend.e_jump && backend.f_taken) begin
      sel.pc = backend.d_npc;
      sel.src = redir_repair;
      valid = 1'b1;
    end else if (bp_out.pred_return) begin
      sel.pc = bp_out.pred_raddr;
      sel.taken = 1'b1;
      sel.src = redir_pred_return;
      valid = 1'b1;
    end else if (bp_out.pred_uncond || (bp_out.pred_branch && bp_out.pred_jump)) begin
      sel.pc = bp_out.pred_baddr;
      sel.taken = 1'b1;
      sel.src = redir_pred_jump;
      valid = 1'b1;
    end else if (backend.m_fence) begin
      sel.pc = backend.e_pc;
      mem_req.fence = 1'b1;
      sel.src = redir_fence;
    end else if (!busy) begin
      // a 32-bit encoding has both low bits set.
      sel.pc = r.pc + ((r.instr[1:0] == 2'b11) ? 32'd4 : 32'd2);
      sel.src = redir_seq;
    end else begin
      sel.src = redir_hold;
    end

    mem_req.valid = valid;
    mem_req.addr = sel.pc;
  end

  always_comb begin
    rin = sel;
    if (mem_rsp.ready) begin
      rin.instr = mem_rsp.rdata;
      rin.stall = 1'b0;
    end else begin
      rin.instr = nop_instr;
      rin.stall = 1'b1;  // hold the pc until the word arrives.
    end

    y.pc = rin.pc;
    y.instr = rin.instr;
    y.taken = rin.taken;
    y.src = rin.src;

    q.pc = r.pc;
    q.instr = r.instr;
    q.taken = r.taken;
    q.src = r.src;
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      r.pc <= reset_pc;
      r.instr <= nop_instr;
      r.taken <= 1'b0;
      r.stall <= 1'b1;  // first cycle loads the word at reset_pc.
      r.src <= redir_hold;
    end else begin
      r <= rin;
    end
  end

endmodule

// ==== design/fetch_top.sv ====
`timescale 1ns/10ps

module fetch_top (
  input  logic                       clk,
  input  logic                       rst,
  input  fetch_pkg::backend_t        backend,
  input  logic                       trap_req,
  input  logic                       mret_req,
  input  logic [fetch_pkg::xlen-1:0] trap_epc,
  input  logic                       csr_we,
  input  fetch_pkg::csr_sel_e        csr_sel,
  input  logic [fetch_pkg::xlen-1:0] csr_wdata,
  output fetch_pkg::fetch_out_t      y,
  output fetch_pkg::fetch_out_t      q
);
  import fetch_pkg::*;

  csr_out_t csr_out;
  bp_in_t   bp_in;
  bp_out_t  bp_out;
  mem_req_t mem_req;
  mem_rsp_t mem_rsp;

  trap_csr trap_csr_inst (
    .clk       (clk),
    .rst       (rst),
    .trap_req  (trap_req),
    .mret_req  (mret_req),
    .trap_epc  (trap_epc),
    .csr_we    (csr_we),
    .csr_sel   (csr_sel),
    .csr_wdata (csr_wdata),
    .csr_out   (csr_out)
  );

  fetch_stage fetch_stage_inst (
    .clk     (clk),
    .rst     (rst),
    .csr_out (csr_out),
    .bp_out  (bp_out),
    .bp_in   (bp_in),
    .mem_rsp (mem_rsp),
    .mem_req (mem_req),
    .backend (backend),
    .y       (y),
    .q       (q)
  );

  branch_predictor branch_predictor_inst (
    .clk    (clk),
    .rst    (rst),
    .bp_in  (bp_in),
    .bp_out (bp_out)
  );

  fetch_buffer fetch_buffer_inst (
    .clk     (clk),
    .rst     (rst),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
  );

endmodule

// ==== design/program.hex ====
// one 16-bit halfword per line in address order, mixing 16-bit and 32-bit encodings
0001
0093
0010
4505
0113
0020
0505
0001
0193
0030
8082
0213
0040
0001
4585
0001

// ==== design/trap_csr.sv ====
`timescale 1ns/10ps

module trap_csr (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      trap_req,
  input  logic                      mret_req,
  input  logic [fetch_pkg::xlen-1:0] trap_epc,
  input  logic                      csr_we,
  input  fetch_pkg::csr_sel_e       csr_sel,
  input  logic [fetch_pkg::xlen-1:0] csr_wdata,
  output fetch_pkg::csr_out_t       csr_out
);
  import fetch_pkg::*;

  logic [xlen-1:0] mtvec;
  logic [xlen-1:0] mepc;
  logic [xlen-1:0] wdata_aligned;

  assign wdata_aligned = {csr_wdata[xlen-1:1], 1'b0};

  always_ff @(posedge clk) begin
    if (!rst) begin
      mtvec <= '0;
      mepc <= '0;
    end else begin
      if (trap_req) begin
        mepc <= {trap_epc[xlen-1:1], 1'b0};  // trap capture beats a CSR write.
      end else if (csr_we && csr_sel == csr_mepc) begin
        mepc <= wdata_aligned;
      end
      if (csr_we && csr_sel == csr_mtvec) begin
        mtvec <= wdata_aligned;
      end
    end
  end

  always_comb begin
    csr_out.trap = trap_req;
    csr_out.mret = mret_req & ~trap_req;  // a trap in the same cycle wins.
    csr_out.mtvec = mtvec;
    csr_out.mepc = mepc;
  end

endmodule

// ==== list.f ====
design/fetch_pkg.sv
design/fetch_stage.sv
design/branch_predictor.sv
design/fetch_buffer.sv
design/trap_csr.sv
design/fetch_top.sv
testbench/fetch_assertions.sv
testbench/fetch_tb.sv

// ==== testbench/fetch_assertions.sv ====
`timescale 1ns/10ps

module fetch_assertions (
  input logic                       clk,
  input logic                       rst,
  input fetch_pkg::backend_t        backend,
  input logic                       trap_req,
  input logic                       mret_req,
  input logic [fetch_pkg::xlen-1:0] trap_epc,
  input logic                       csr_we,
  input fetch_pkg::csr_sel_e        csr_sel,
  input logic [fetch_pkg::xlen-1:0] csr_wdata,
  input fetch_pkg::csr_out_t        csr_out,
  input fetch_pkg::bp_in_t          bp_in,
  input fetch_pkg::bp_out_t         bp_out,
  input fetch_pkg::mem_req_t        mem_req,
  input fetch_pkg::mem_rsp_t        mem_rsp,
  input fetch_pkg::fetch_out_t      y,
  input fetch_pkg::fetch_out_t      q
);
  import fetch_pkg::*;

  int              fail_count = 0;
  logic [xlen-1:0] learn_pc;
  logic [xlen-1:0] learn_addr;
  logic [1:0]      learn_hits;  // taken updates seen for learn_pc.
  logic [xlen-1:0] last_push;
  logic            push_seen;
  logic [xlen-1:0] exp_mtvec;
  logic [xlen-1:0] exp_mepc;
  logic            quiet;
  logic            no_lookup;
  logic            stall_any;

  // halfwords of program.hex; memory past the image holds c.nop.
  function automatic logic [15:0] image_half(input logic [xlen-1:0] addr);
    case (addr[xlen-1:1])
      0: return 16'h0001;
      1: return 16'h0093;
      2: return 16'h0010;
      3: return 16'h4505;
      4: return 16'h0113;
      5: return 16'h0020;
      6: return 16'h0505;
      7: return 16'h0001;
      8: return 16'h0193;
      9: return 16'h0030;
      10: return 16'h8082;
      11: return 16'h0213;
      12: return 16'h0040;
      13: return 16'h0001;
      14: return 16'h4585;
      default: return 16'h0001;
    endcase
  endfunction

  assign quiet = !trap_req && !mret_req && !backend.e_jump && !backend.f_taken;
  assign no_lookup = !backend.d_branch && !backend.d_return_pop && !backend.d_jump_uncond;
  assign stall_any = backend.d_stall || backend.e_stall || backend.m_stall;

  always_ff @(posedge clk) begin
    if (!rst) begin
      learn_pc <= '0;
      learn_addr <= '0;
      learn_hits <= '0;
      push_seen <= 1'b0;
      last_push <= '0;
    end else if (!bp_in.stall) begin
      if (bp_in.upd_branch && bp_in.upd_jump) begin
        learn_pc <= bp_in.upd_pc;
        learn_addr <= bp_in.upd_addr;
        learn_hits <= (bp_in.upd_pc == learn_pc && learn_hits != 2'd3) ? learn_hits + 2'd1 : 2'd1;
      end
      if (bp_in.upd_return) begin
        push_seen <= 1'b1;
        last_push <= bp_in.upd_npc;
      end else if (backend.d_return_pop) begin
        push_seen <= 1'b0;
      end
    end
  end

  // CSR writes land with the low bit cleared, and a trap captures its epc.
  always_ff @(posedge clk) begin
    if (!rst) begin
      exp_mtvec <= '0;
      exp_mepc <= '0;
    end else begin
      if (csr_we && csr_sel == csr_mtvec) begin
        exp_mtvec <= {csr_wdata[xlen-1:1], 1'b0};
      end
      if (trap_req) begin
        exp_mepc <= {trap_epc[xlen-1:1], 1'b0};
      end else if (csr_we && csr_sel == csr_mepc) begin
        exp_mepc <= {csr_wdata[xlen-1:1], 1'b0};
      end
    end
  end

  a_reset_state: assert property (@(posedge clk) disable iff (!rst)
    $rose(rst) |-> q.pc == reset_pc && !q.taken && q.instr == nop_instr && mem_req.valid
      && !mem_req.fence && !csr_out.trap && !csr_out.mret && csr_out.mtvec == '0
      && csr_out.mepc == '0 && !bp_out.pred_jump && !bp_out.pred_return)
    else begin fail_count++; $error("FAIL %0t: state after reset is wrong", $time); end

  a_seq_step: assert property (@(posedge clk) disable iff (!rst)
    $past(rst) && $past(mem_rsp.ready) && quiet && no_lookup && !stall_any
      && !backend.w_clear && !backend.m_fence |=>
      q.pc == $past(q.pc) + (($past(q.instr[1:0]) == 2'b11) ? 32'd4 : 32'd2)
      && q.src == redir_seq)
    else begin fail_count++; $error("FAIL %0t: sequential pc step wrong", $time); end

  a_image: assert property (@(posedge clk) disable iff (!rst)
    $past(rst) && $past(mem_rsp.ready) && q.pc < 32'd510 |->
      q.instr == {image_half(q.pc + 32'd2), image_half(q.pc)})
    else begin fail_count++; $error("FAIL %0t: instr %h at pc %h", $time, q.instr, q.pc); end

  a_csr_write: assert property (@(posedge clk) disable iff (!rst)
    csr_out.mtvec == exp_mtvec && csr_out.mepc == exp_mepc)
    else begin fail_count++; $error("FAIL %0t: mtvec or mepc value wrong", $time); end

  a_trap: assert property (@(posedge clk) disable iff (!rst)
    trap_req |-> y.pc == exp_mtvec && y.src == redir_trap
      ##1 q.pc == $past(exp_mtvec) && q.src == redir_trap
      && csr_out.mepc == {$past(trap_epc[xlen-1:1]), 1'b0})
    else begin fail_count++; $error("FAIL %0t: trap redirect or mepc wrong", $time); end

  a_mret: assert property (@(posedge clk) disable iff (!rst)
    mret_req && !trap_req |-> y.pc == exp_mepc && y.src == redir_mret
      ##1 q.pc == $past(exp_mepc) && q.src == redir_mret)
    else begin fail_count++; $error("FAIL %0t: mret redirect wrong", $time); end

  a_repair_jump: assert property (@(posedge clk) disable iff (!rst)
    !trap_req && !mret_req && backend.e_jump && !backend.f_taken |=>
      q.pc == $past(backend.e_address) && q.src == redir_repair)
    else begin fail_count++; $error("FAIL %0t: missed jump not repaired", $time); end

  a_repair_nojump: assert property (@(posedge clk) disable iff (!rst)
    !trap_req && !mret_req && !backend.e_jump && backend.f_taken |=>
      q.pc == $past(backend.d_npc) && q.src == redir_repair)
    else begin fail_count++; $error("FAIL %0t: false taken not repaired", $time); end

  a_learned: assert property (@(posedge clk) disable iff (!rst)
    quiet && backend.d_branch && backend.d_pc == learn_pc && learn_hits >= 2'd2
      && !backend.d_return_pop |=> q.pc == $past(learn_addr) && q.taken)
    else begin fail_count++; $error("FAIL %0t: learned branch not predicted", $time); end

  a_return: assert property (@(posedge clk) disable iff (!rst)
    quiet && backend.d_return_pop && push_seen && !bp_in.stall |=>
      q.pc == $past(last_push) && q.taken && q.src == redir_pred_return)
    else begin fail_count++; $error("FAIL %0t: return not predicted", $time); end

  a_stall: assert property (@(posedge clk) disable iff (!rst)
    quiet && no_lookup && stall_any && !backend.m_fence |-> !mem_req.valid ##1 q.pc == $past(q.pc))
    else begin fail_count++; $error("FAIL %0t: pc moved or fetch issued under stall", $time); end

  a_fence: assert property (@(posedge clk) disable iff (!rst)
    quiet && no_lookup && backend.m_fence |=> q.pc == $past(backend.e_pc) && q.src == redir_fence
      ##1 q.instr == nop_instr ##1 q.instr != nop_instr)
    else begin fail_count++; $error("FAIL %0t: fence refetch sequence wrong", $time); end

endmodule

bind fetch_top fetch_assertions fetch_assertions_inst (
  .clk       (clk),
  .rst       (rst),
  .backend   (backend),
  .trap_req  (trap_req),
  .mret_req  (mret_req),
  .trap_epc  (trap_epc),
  .csr_we    (csr_we),
  .csr_sel   (csr_sel),
  .csr_wdata (csr_wdata),
  .csr_out   (csr_out),
  .bp_in     (bp_in),
  .bp_out    (bp_out),
  .mem_req   (mem_req),
  .mem_rsp   (mem_rsp),
  .y         (y),
  .q         (q)
);

// ==== testbench/fetch_tb.sv ====
`timescale 1ns/10ps

module fetch_tb;
  import fetch_pkg::*;

  // test lengths in cycles: reset, sequential, trap, repair, learning, stall and fence, then margin.
  localparam int timeout_cycles = 6 + 24 + 20 + 8 + 14 + 24 + 60;

  logic            clk;
  logic            rst;
  backend_t        backend;
  logic            trap_req;
  logic            mret_req;
  logic [xlen-1:0] trap_epc;
  logic            csr_we;
  csr_sel_e        csr_sel;
  logic [xlen-1:0] csr_wdata;
  fetch_out_t      y;
  fetch_out_t      q;
  logic [31:0]     lfsr_state = 32'h1b21;
  int              cycles = 0;
  int              errors;

  fetch_top fetch_top_inst (
    .clk       (clk),
    .rst       (rst),
    .backend   (backend),
    .trap_req  (trap_req),
    .mret_req  (mret_req),
    .trap_epc  (trap_epc),
    .csr_we    (csr_we),
    .csr_sel   (csr_sel),
    .csr_wdata (csr_wdata),
    .y         (y),
    .q         (q)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32, 22, 2, 1.
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  task automatic drive(input backend_t b);
    @(posedge clk);
    backend <= b;
    trap_req <= 1'b0;
    mret_req <= 1'b0;
    csr_we <= 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) drive('0);
  endtask

  task automatic write_csr(input csr_sel_e sel, input logic [xlen-1:0] val);
    @(posedge clk);
    backend <= '0;
    csr_we <= 1'b1;
    csr_sel <= sel;
    csr_wdata <= val;
  endtask

  task automatic pulse_trap(input logic t, input logic m, input logic [xlen-1:0] epc);
    @(posedge clk);
    backend <= '0;
    csr_we <= 1'b0;
    trap_req <= t;
    mret_req <= m;
    trap_epc <= epc;
  endtask

  task automatic apply_reset(input backend_t b);
    @(posedge clk);
    rst <= 1'b0;
    backend <= b;
    trap_req <= 1'b0;
    mret_req <= 1'b0;
    csr_we <= 1'b0;
    repeat (4) @(posedge clk);
    rst <= 1'b1;
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("timeout: run did not finish within %0d cycles", timeout_cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    backend_t    b;
    logic [31:0] v;
    logic [31:0] w;
    rst = 1'b0;
    backend = '0;
    trap_req = 1'b0;
    mret_req = 1'b0;
    trap_epc = '0;
    csr_we = 1'b0;
    csr_sel = csr_mtvec;
    csr_wdata = '0;
    repeat (4) @(posedge clk);
    rst <= 1'b1;

    idle(24);  // sequential walk through the image and beyond.

    take_bits(5, v);
    write_csr(csr_mtvec, {v[4:0], 1'b1});  // low bit is cleared on write.
    take_bits(5, w);
    write_csr(csr_mepc, {w[4:0], 1'b0});
    take_bits(5, v);
    pulse_trap(1'b1, 1'b0, {v[4:0], 1'b0});
    idle(3);
    pulse_trap(1'b0, 1'b1, '0);
    idle(3);
    pulse_trap(1'b1, 1'b1, 32'h0000_0008);
    idle(3);

    b = '0;
    b.e_jump = 1'b1;
    b.e_address = 32'h0000_0010;
    drive(b);
    b = '0;
    b.f_taken = 1'b1;
    b.d_npc = 32'h0000_0016;
    drive(b);
    idle(3);

    b = '0;
    b.e_branch = 1'b1;
    b.e_jump = 1'b1;
    b.e_pc = 32'h0000_0040;
    b.e_address = 32'h0000_0008;
    drive(b);
    drive(b);
    idle(1);
    b = '0;
    b.d_branch = 1'b1;
    b.d_pc = 32'h0000_0040;
    drive(b);
    idle(2);
    b = '0;
    b.e_return_push = 1'b1;
    b.e_npc = 32'h0000_0016;
    drive(b);
    b = '0;
    b.d_return_pop = 1'b1;
    drive(b);
    idle(3);

    for (int i = 0; i < 12; i++) begin
      take_bits(3, v);
      b = '0;
      b.d_stall = v[0];
      b.e_stall = v[1];
      b.m_stall = v[2];
      drive(b);
    end
    idle(2);
    b = '0;
    b.m_fence = 1'b1;
    b.e_pc = 32'h0000_0006;
    drive(b);
    idle(5);

    b = '0;
    b.e_return_push = 1'b1;
    b.e_npc = 32'h0000_0020;
    drive(b);  // this entry and the learned branch must not survive reset.
    b = '0;
    b.d_branch = 1'b1;
    b.d_pc = 32'h0000_0040;
    b.d_return_pop = 1'b1;
    apply_reset(b);  // lookups stay on while reset is released.
    idle(4);

    errors = fetch_top_inst.fetch_assertions_inst.fail_count;
    $display("assertion failures: %0d, cycles run: %0d", errors, cycles);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
